// File: Bender.yml
package:
  name: lsu_subsystem

sources:
  - include_dirs:
      - src
    files:
      - src/lsu_pkg.sv
      - src/load_store_unit.sv
      - src/mem_event_counters.sv
      - src/csr_access.sv
      - src/lsu_subsystem.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/tb_lsu_subsystem.sv

// File: sim.f
+incdir+src
src/lsu_pkg.sv
src/load_store_unit.sv
src/mem_event_counters.sv
src/csr_access.sv
src/lsu_subsystem.sv
tb/tb_lsu_subsystem.sv

// File: src/csr_access.sv
/*
 * CSR access port with debug over pipeline arbitration and address decode
 * Read mux, WRITE/SET/CLEAR update, scratch register, counter write port
 */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_macros.svh"

module csr_access import lsu_pkg::*; (
  input  wire logic                   clk,
  input  wire logic                   rst_ni,
  // Pipeline request
  input  wire logic                   csr_access_i,
  input  wire csr_op_e                csr_op_i,
  input  wire logic [`CSR_ADDR_W-1:0] csr_addr_i,
  input  wire logic [`LSU_XLEN-1:0]   csr_wdata_i,
  // Debug request
  input  wire logic                   dbg_csr_req_i,
  input  wire logic [`CSR_ADDR_W-1:0] dbg_csr_addr_i,
  input  wire logic                   dbg_csr_we_i,
  input  wire logic [`LSU_XLEN-1:0]   dbg_csr_wdata_i,
  output logic [`LSU_XLEN-1:0]        csr_rdata_o,
  // Counter side
  input  wire logic [`LSU_XLEN-1:0]   load_cnt_i,
  input  wire logic [`LSU_XLEN-1:0]   store_cnt_i,
  input  wire logic [`LSU_XLEN-1:0]   err_cnt_i,
  output logic                        cnt_we_o,
  output cnt_sel_e                    cnt_sel_o,
  output logic [`LSU_XLEN-1:0]        cnt_wdata_o
);

  logic                   access;
  csr_op_e                op;
  logic [`CSR_ADDR_W-1:0] addr;
  logic [`LSU_XLEN-1:0]   wdata;
  logic                   addr_hit;
  logic                   is_scratch;
  logic [`LSU_XLEN-1:0]   old_val;
  logic [`LSU_XLEN-1:0]   new_val;
  logic                   csr_we;
  logic [`LSU_XLEN-1:0]   mscratch_q;

  ////////////////////////////////////////////////////////////////////////////
  // Debug over pipeline arbitration
  ////////////////////////////////////////////////////////////////////////////

  assign access = dbg_csr_req_i | csr_access_i;
  assign addr   = dbg_csr_req_i ? dbg_csr_addr_i : csr_addr_i;
  assign wdata  = dbg_csr_req_i ? dbg_csr_wdata_i : csr_wdata_i;
  // Debug write is a plain write, a debug read touches nothing
  assign op     = dbg_csr_req_i ? (dbg_csr_we_i ? WRITE : NONE) : csr_op_i;

  // Address decode and old value
  always_comb begin
    addr_hit   = 1'b1;
    is_scratch = 1'b0;
    cnt_sel_o  = LOADS;
    old_val    = '0;
    case (addr)
      `CSR_MSCRATCH: begin
        is_scratch = 1'b1;
        old_val    = mscratch_q;
      end
      `CSR_LOAD_CNT:  old_val = load_cnt_i;
      `CSR_STORE_CNT: begin
        cnt_sel_o = STORES;
        old_val   = store_cnt_i;
      end
      `CSR_ERR_CNT: begin
        cnt_sel_o = ERRORS;
        old_val   = err_cnt_i;
      end
      // Unmapped address reads zero
      default: addr_hit = 1'b0;
    endcase
  end

  // Read-modify-write
  always_comb begin
    case (op)
      WRITE:   new_val = wdata;
      SET:     new_val = old_val | wdata;
      CLEAR:   new_val = old_val & ~wdata;
      default: new_val = old_val;
    endcase
  end

  assign csr_we      = access & (op != NONE) & addr_hit;
  assign csr_rdata_o = access ? old_val : '0;
  assign cnt_we_o    = csr_we & ~is_scratch;
  assign cnt_wdata_o = new_val;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      mscratch_q <= '0;
    end else if (csr_we && is_scratch) begin
      mscratch_q <= new_val;
    end
  end

  // Counter write strobe only for one of the three counter addresses
  a_unknown_no_write: assert property (@(posedge clk) disable iff (!rst_ni)
    cnt_we_o |-> addr inside {`CSR_LOAD_CNT, `CSR_STORE_CNT, `CSR_ERR_CNT});

endmodule

`default_nettype wire

// File: src/load_store_unit.sv
/*
 * Load/store unit: one req/gnt/rvalid bus transaction per pipeline request
 * Byte enables, write data lane rotation, load extraction and extension
 */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_macros.svh"

module load_store_unit import lsu_pkg::*; (
  input  wire logic                 clk,
  input  wire logic                 rst_ni,
  // Pipeline request
  input  wire logic                 lsu_req_i,
  input  wire logic                 lsu_we_i,
  input  wire data_type_e           lsu_type_i,
  input  wire logic                 lsu_sign_ext_i,
  input  wire logic [`LSU_XLEN-1:0] lsu_addr_i,
  input  wire logic [`LSU_XLEN-1:0] lsu_wdata_i,
  // Pipeline response
  output logic [`LSU_XLEN-1:0]      lsu_rdata_o,
  output logic                      lsu_valid_o,
  output logic                      load_err_o,
  output logic                      store_err_o,
  output logic                      misaligned_o,
  output logic                      lsu_busy_o,
  // Data bus
  output logic                      data_req_o,
  input  wire logic                 data_gnt_i,
  input  wire logic                 data_rvalid_i,
  input  wire logic                 data_err_i,
  output logic [`LSU_XLEN-1:0]      data_addr_o,
  output logic                      data_we_o,
  output logic [`LSU_BE_W-1:0]      data_be_o,
  output logic [`LSU_XLEN-1:0]      data_wdata_o,
  input  wire logic [`LSU_XLEN-1:0] data_rdata_i
);

  lsu_state_e           state_q;
  // Registered request, held for the whole transaction
  logic [`LSU_XLEN-1:0] addr_q;
  logic                 we_q;
  data_type_e           type_q;
  logic                 sign_q;
  logic [`LSU_BE_W-1:0] be_q;
  logic [`LSU_XLEN-1:0] wdata_q;
  // Response side
  logic [`LSU_XLEN-1:0] rdata_q;
  logic                 valid_q;
  logic                 load_err_q;
  logic                 store_err_q;
  logic                 misaligned_q;
  // Request decode
  logic [1:0]           req_offset;
  logic                 accept;
  logic                 req_misaligned;
  logic [`LSU_BE_W-1:0] req_be;
  logic [`LSU_XLEN-1:0] req_wdata;
  // Load path
  logic [`LSU_XLEN-1:0] rdata_shifted;
  logic [`LSU_XLEN-1:0] rdata_ext;

  ////////////////////////////////////////////////////////////////////////////
  // Request decode
  ////////////////////////////////////////////////////////////////////////////

  assign req_offset = lsu_addr_i[1:0];
  // New requests only while idle, everything else is dropped
  assign accept     = lsu_req_i & ~lsu_busy_o;

  // Word needs offset 0, half-word must not cross the word
  always_comb begin
    case (lsu_type_i)
      WORD:    req_misaligned = (req_offset != 2'b00);
      HALF:    req_misaligned = (req_offset == 2'b11);
      default: req_misaligned = 1'b0;
    endcase
  end

  // Enabled lanes start at the byte offset
  always_comb begin
    case (lsu_type_i)
      HALF:    req_be = `LSU_BE_W'(2'b11) << req_offset;
      BYTE:    req_be = `LSU_BE_W'(1'b1) << req_offset;
      default: req_be = {`LSU_BE_W{1'b1}};
    endcase
  end

  // Rotate store data so byte 0 lands in the addressed lane
  always_comb begin
    case (req_offset)
      2'b01:   req_wdata = {lsu_wdata_i[23:0], lsu_wdata_i[31:24]};
      2'b10:   req_wdata = {lsu_wdata_i[15:0], lsu_wdata_i[31:16]};
      2'b11:   req_wdata = {lsu_wdata_i[7:0], lsu_wdata_i[31:8]};
      default: req_wdata = lsu_wdata_i;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Load extraction
  ////////////////////////////////////////////////////////////////////////////

  // Addressed byte down to lane 0
  assign rdata_shifted = data_rdata_i >> {addr_q[1:0], 3'b000};

  always_comb begin
    case (type_q)
      BYTE: begin
        rdata_ext = {{(`LSU_XLEN-8){sign_q & rdata_shifted[7]}}, rdata_shifted[7:0]};
      end
      HALF: begin
        rdata_ext = {{(`LSU_XLEN-16){sign_q & rdata_shifted[15]}}, rdata_shifted[15:0]};
      end
      default: rdata_ext = rdata_shifted;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Transaction FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      addr_q       <= '0;
      we_q         <= 1'b0;
      type_q       <= WORD;
      sign_q       <= 1'b0;
      be_q         <= '0;
      wdata_q      <= '0;
      rdata_q      <= '0;
      valid_q      <= 1'b0;
      load_err_q   <= 1'b0;
      store_err_q  <= 1'b0;
      misaligned_q <= 1'b0;
    end else begin
      // End strobes are single-cycle
      valid_q      <= 1'b0;
      load_err_q   <= 1'b0;
      store_err_q  <= 1'b0;
      misaligned_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (accept && req_misaligned) begin
            // Rejected, no bus traffic
            misaligned_q <= 1'b1;
          end else if (accept) begin
            state_q <= WAIT_GNT;
            addr_q  <= lsu_addr_i;
            we_q    <= lsu_we_i;
            type_q  <= lsu_type_i;
            sign_q  <= lsu_sign_ext_i;
            be_q    <= req_be;
            wdata_q <= req_wdata;
          end
        end
        WAIT_GNT: begin
          // address phase done on grant
          if (data_gnt_i) begin
            state_q <= WAIT_RVALID;
          end
        end
        WAIT_RVALID: begin
          if (data_rvalid_i) begin
            state_q     <= IDLE;
            valid_q     <= 1'b1;
            rdata_q     <= we_q ? '0 : rdata_ext;
            load_err_q  <= data_err_i & ~we_q;
            store_err_q <= data_err_i & we_q;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Bus side
  assign data_req_o   = (state_q == WAIT_GNT);
  assign data_addr_o  = {addr_q[`LSU_XLEN-1:2], 2'b00};
  assign data_we_o    = we_q;
  assign data_be_o    = be_q;
  assign data_wdata_o = wdata_q;

  // Pipeline side, busy until the end pulse has gone out
  assign lsu_rdata_o  = rdata_q;
  assign lsu_valid_o  = valid_q;
  assign load_err_o   = load_err_q;
  assign store_err_o  = store_err_q;
  assign misaligned_o = misaligned_q;
  assign lsu_busy_o   = (state_q != IDLE) | valid_q | misaligned_q;

  // Back-pressure keeps the whole request frozen
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_ni)
    data_req_o && !data_gnt_i |=> data_req_o && $stable(data_addr_o) &&
      $stable(data_we_o) && $stable(data_be_o) && $stable(data_wdata_o));

endmodule

`default_nettype wire

// File: src/lsu_macros.svh
/*
 * Architectural widths of the data path
 * CSR addresses of the scratch register and the memory event counters
 */
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// One data word, also the address width
`define LSU_XLEN      32
// One enable per byte lane
`define LSU_BE_W      4

// CSR address space
`define CSR_ADDR_W    12
`define CSR_MSCRATCH  12'h340
// Memory event counters
`define CSR_LOAD_CNT  12'hB03
`define CSR_STORE_CNT 12'hB04
`define CSR_ERR_CNT   12'hB05

`endif

// File: src/lsu_pkg.sv
/*
 * Shared enums: access size, LSU states, CSR operations, counter select
 */
`default_nettype none

package lsu_pkg;

  // Access size of a load or store
  typedef enum logic [1:0] {
    WORD = 2'b00,
    HALF = 2'b01,
    BYTE = 2'b10
  } data_type_e;

  // Bus transaction FSM
  typedef enum logic [1:0] {
    IDLE        = 2'b00,
    WAIT_GNT    = 2'b01,
    WAIT_RVALID = 2'b10
  } lsu_state_e;

  // CSR read-modify-write operations
  typedef enum logic [1:0] {
    NONE  = 2'b00,
    WRITE = 2'b01,
    SET   = 2'b10,
    CLEAR = 2'b11
  } csr_op_e;

  // Counter index, shared by the CSR decode and the counter block
  typedef enum logic [1:0] {
    LOADS  = 2'd0,
    STORES = 2'd1,
    ERRORS = 2'd2
  } cnt_sel_e;

endpackage

`default_nettype wire

// File: src/lsu_subsystem.sv
/*
 * Data-memory subsystem top: LSU, memory event counters, CSR access port
 */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_macros.svh"

module lsu_subsystem import lsu_pkg::*; (
  input  wire logic                   clk,
  input  wire logic                   rst_ni,
  // Pipeline LSU port
  input  wire logic                   lsu_req_i,
  input  wire logic                   lsu_we_i,
  input  wire data_type_e             lsu_type_i,
  input  wire logic                   lsu_sign_ext_i,
  input  wire logic [`LSU_XLEN-1:0]   lsu_addr_i,
  input  wire logic [`LSU_XLEN-1:0]   lsu_wdata_i,
  output logic [`LSU_XLEN-1:0]        lsu_rdata_o,
  output logic                        lsu_valid_o,
  output logic                        load_err_o,
  output logic                        store_err_o,
  output logic                        misaligned_o,
  output logic                        lsu_busy_o,
  // Data bus
  output logic                        data_req_o,
  input  wire logic                   data_gnt_i,
  input  wire logic                   data_rvalid_i,
  input  wire logic                   data_err_i,
  output logic [`LSU_XLEN-1:0]        data_addr_o,
  output logic                        data_we_o,
  output logic [`LSU_BE_W-1:0]        data_be_o,
  output logic [`LSU_XLEN-1:0]        data_wdata_o,
  input  wire logic [`LSU_XLEN-1:0]   data_rdata_i,
  // Pipeline CSR port
  input  wire logic                   csr_access_i,
  input  wire csr_op_e                csr_op_i,
  input  wire logic [`CSR_ADDR_W-1:0] csr_addr_i,
  input  wire logic [`LSU_XLEN-1:0]   csr_wdata_i,
  // Debug CSR port
  input  wire logic                   dbg_csr_req_i,
  input  wire logic [`CSR_ADDR_W-1:0] dbg_csr_addr_i,
  input  wire logic                   dbg_csr_we_i,
  input  wire logic [`LSU_XLEN-1:0]   dbg_csr_wdata_i,
  output logic [`LSU_XLEN-1:0]        csr_rdata_o
);

  // Counter values and CSR write port
  logic [`LSU_XLEN-1:0] load_cnt;
  logic [`LSU_XLEN-1:0] store_cnt;
  logic [`LSU_XLEN-1:0] err_cnt;
  logic                 cnt_we;
  cnt_sel_e             cnt_sel;
  logic [`LSU_XLEN-1:0] cnt_wdata;

  // Port names match the top one to one
  load_store_unit u_load_store_unit (.*);

  // Counters watch the same bus wires the LSU drives
  mem_event_counters u_mem_event_counters (
    .clk           ( clk           ),
    .rst_ni        ( rst_ni        ),
    .data_req_i    ( data_req_o    ),
    .data_gnt_i    ( data_gnt_i    ),
    .data_we_i     ( data_we_o     ),
    .data_rvalid_i ( data_rvalid_i ),
    .data_err_i    ( data_err_i    ),
    .cnt_we_i      ( cnt_we        ),
    .cnt_sel_i     ( cnt_sel       ),
    .cnt_wdata_i   ( cnt_wdata     ),
    .load_cnt_o    ( load_cnt      ),
    .store_cnt_o   ( store_cnt     ),
    .err_cnt_o     ( err_cnt       )
  );

  // CSR ports by name, counter side explicit
  csr_access u_csr_access (
    .*,
    .load_cnt_i  ( load_cnt  ),
    .store_cnt_i ( store_cnt ),
    .err_cnt_i   ( err_cnt   ),
    .cnt_we_o    ( cnt_we    ),
    .cnt_sel_o   ( cnt_sel   ),
    .cnt_wdata_o ( cnt_wdata )
  );

endmodule

`default_nettype wire

// File: src/mem_event_counters.sv
/*
 * Memory event counters for granted loads, granted stores and error responses
 * Write port from the CSR block overrides an increment
 */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_macros.svh"

module mem_event_counters import lsu_pkg::*; (
  input  wire logic                 clk,
  input  wire logic                 rst_ni,
  // Observed bus
  input  wire logic                 data_req_i,
  input  wire logic                 data_gnt_i,
  input  wire logic                 data_we_i,
  input  wire logic                 data_rvalid_i,
  input  wire logic                 data_err_i,
  // CSR write port
  input  wire logic                 cnt_we_i,
  input  wire cnt_sel_e             cnt_sel_i,
  input  wire logic [`LSU_XLEN-1:0] cnt_wdata_i,
  // Counter values
  output logic [`LSU_XLEN-1:0]      load_cnt_o,
  output logic [`LSU_XLEN-1:0]      store_cnt_o,
  output logic [`LSU_XLEN-1:0]      err_cnt_o
);

  logic                 load_event;
  logic                 store_event;
  logic                 err_event;
  logic [2:0]           cnt_inc;
  logic [`LSU_XLEN-1:0] cnt_q [3];

  // Address phase completes on req and gnt
  assign load_event  = data_req_i & data_gnt_i & ~data_we_i;
  assign store_event = data_req_i & data_gnt_i & data_we_i;
  // Error travels with the response
  assign err_event   = data_rvalid_i & data_err_i;

  // Increment vector indexed like the select
  assign cnt_inc[LOADS]  = load_event;
  assign cnt_inc[STORES] = store_event;
  assign cnt_inc[ERRORS] = err_event;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < 3; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 3; i++) begin
        // CSR write wins over an increment
        if (cnt_we_i && (int'(cnt_sel_i) == i)) begin
          cnt_q[i] <= cnt_wdata_i;
        end else if (cnt_inc[i]) begin
          cnt_q[i] <= cnt_q[i] + `LSU_XLEN'(1);
        end
      end
    end
  end

  assign load_cnt_o  = cnt_q[LOADS];
  assign store_cnt_o = cnt_q[STORES];
  assign err_cnt_o   = cnt_q[ERRORS];

  // A grant only answers a pending request
  a_gnt_with_req: assert property (@(posedge clk) disable iff (!rst_ni)
    data_gnt_i |-> data_req_i);

endmodule

`default_nettype wire

// File: tb/tb_lsu_subsystem.sv
/*
 * Directed testbench for the data-memory subsystem
 * Word memory model with random grant and response latency, check task, test tasks
 */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_macros.svh"

module tb_lsu_subsystem import lsu_pkg::*; ();

  localparam int          CLK_PERIOD = 8;
  localparam int          TIMEOUT    = 50;
  localparam logic [31:0] SEED       = 32'hba22_9b1f;
  localparam logic [31:0] MEM_BASE   = 32'h1000_0000;
  // Responses to this word carry the error flag
  localparam logic [31:0] ERR_ADDR   = MEM_BASE + 32'h0000_00F0;

  logic                   clk;
  logic                   rst_ni;
  logic                   lsu_req_i;
  logic                   lsu_we_i;
  data_type_e             lsu_type_i;
  logic                   lsu_sign_ext_i;
  logic [`LSU_XLEN-1:0]   lsu_addr_i;
  logic [`LSU_XLEN-1:0]   lsu_wdata_i;
  logic [`LSU_XLEN-1:0]   lsu_rdata_o;
  logic                   lsu_valid_o;
  logic                   load_err_o;
  logic                   store_err_o;
  logic                   misaligned_o;
  logic                   lsu_busy_o;
  logic                   data_req_o;
  logic                   data_gnt_i;
  logic                   data_rvalid_i;
  logic                   data_err_i;
  logic [`LSU_XLEN-1:0]   data_addr_o;
  logic                   data_we_o;
  logic [`LSU_BE_W-1:0]   data_be_o;
  logic [`LSU_XLEN-1:0]   data_wdata_o;
  logic [`LSU_XLEN-1:0]   data_rdata_i;
  logic                   csr_access_i;
  csr_op_e                csr_op_i;
  logic [`CSR_ADDR_W-1:0] csr_addr_i;
  logic [`LSU_XLEN-1:0]   csr_wdata_i;
  logic                   dbg_csr_req_i;
  logic [`CSR_ADDR_W-1:0] dbg_csr_addr_i;
  logic                   dbg_csr_we_i;
  logic [`LSU_XLEN-1:0]   dbg_csr_wdata_i;
  logic [`LSU_XLEN-1:0]   csr_rdata_o;

  // 64-word window above MEM_BASE
  logic [31:0] mem [64];
  // Bus address of the last granted request
  logic [31:0] granted_addr;
  int          checks;
  int          errors;
  // Bus events the counters should have seen
  int          exp_loads;
  int          exp_stores;
  int          exp_errs;

  lsu_subsystem u_lsu_subsystem (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////////////////////////////////////////

  // Mixes every address bit into the initial contents
  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]};
  endfunction

  function automatic logic is_aligned(input data_type_e dt, input int off);
    if (dt == WORD) return off == 0;
    if (dt == HALF) return off != 3;
    return 1'b1;
  endfunction

  // Store writes its low bytes starting at the offset
  function automatic logic [31:0] merge_store(input logic [31:0] old, input data_type_e dt,
                                              input int off, input logic [31:0] d);
    logic [31:0] w;
    int          n;
    int          i;
    w = old;
    n = (dt == WORD) ? 4 : ((dt == HALF) ? 2 : 1);
    for (i = 0; i < n; i++) begin
      w[8*(off+i) +: 8] = d[8*i +: 8];
    end
    return w;
  endfunction

  function automatic logic [31:0] load_expect(input logic [31:0] w, input data_type_e dt,
                                              input int off, input logic sx);
    logic [7:0]  b;
    logic [15:0] h;
    case (dt)
      BYTE: begin
        b = w[8*off +: 8];
        return {{24{sx & b[7]}}, b};
      end
      HALF: begin
        h = w[8*off +: 16];
        return {{16{sx & h[15]}}, h};
      end
      default: return w;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////////////////////////////////////////

  initial begin : mem_model
    int unsigned gnt_wait;
    int unsigned rsp_wait;
    logic [31:0] addr;
    logic        we;
    logic [3:0]  be;
    logic [31:0] wd;
    int          i;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_err_i    = 1'b0;
    data_rdata_i  = '0;
    granted_addr  = '0;
    forever begin
      @(negedge clk);
      if (rst_ni && data_req_o) begin
        // Grant after 0 to 3 cycles
        gnt_wait = $urandom_range(3, 0);
        repeat (gnt_wait) @(negedge clk);
        addr         = data_addr_o;
        we           = data_we_o;
        be           = data_be_o;
        wd           = data_wdata_o;
        granted_addr = addr;
        data_gnt_i   = 1'b1;
        @(negedge clk);
        data_gnt_i = 1'b0;
        // Response 1 to 3 cycles after the grant
        rsp_wait = $urandom_range(2, 0);
        repeat (rsp_wait) @(negedge clk);
        data_err_i   = (addr == ERR_ADDR);
        data_rdata_i = mem[addr[7:2]];
        if (we && addr != ERR_ADDR) begin
          for (i = 0; i < 4; i++) begin
            if (be[i]) mem[addr[7:2]][8*i +: 8] = wd[8*i +: 8];
          end
        end
        data_rvalid_i = 1'b1;
        @(negedge clk);
        data_rvalid_i = 1'b0;
        data_err_i    = 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Driver and check tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int start);
    $display("Test %-10s finished, %0d errors", name, errors - start);
  endtask

  // One request and its end pulse
  task automatic lsu_access(input logic we, input data_type_e dt, input logic sx,
                            input logic [31:0] addr, input logic [31:0] wd,
                            output logic [31:0] rd, output logic lerr, output logic serr);
    int n;
    n = 0;
    @(negedge clk);
    lsu_req_i      = 1'b1;
    lsu_we_i       = we;
    lsu_type_i     = dt;
    lsu_sign_ext_i = sx;
    lsu_addr_i     = addr;
    lsu_wdata_i    = wd;
    @(negedge clk);
    lsu_req_i = 1'b0;
    while (!lsu_valid_o && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!lsu_valid_o) begin
      errors++;
      $display("Timeout: no lsu_valid_o within %0d cycles for address %h", TIMEOUT, addr);
    end
    rd   = lsu_rdata_o;
    lerr = load_err_o;
    serr = store_err_o;
    // Bus sees the word that holds the addressed bytes
    check("bus address", granted_addr, addr & ~32'h3);
    if (we) exp_stores++;
    else exp_loads++;
    if ({addr[31:2], 2'b00} == ERR_ADDR) exp_errs++;
    @(negedge clk);
  endtask

  // Read sampled mid-cycle and the write lands at the next edge
  task automatic csr_cycle(input logic pipe, input csr_op_e op, input logic [11:0] addr,
                           input logic [31:0] wd, input logic dbg, input logic dbg_we,
                           input logic [11:0] dbg_addr, input logic [31:0] dbg_wd,
                           output logic [31:0] rd);
    @(negedge clk);
    csr_access_i    = pipe;
    csr_op_i        = op;
    csr_addr_i      = addr;
    csr_wdata_i     = wd;
    dbg_csr_req_i   = dbg;
    dbg_csr_we_i    = dbg_we;
    dbg_csr_addr_i  = dbg_addr;
    dbg_csr_wdata_i = dbg_wd;
    #(CLK_PERIOD / 4);
    rd = csr_rdata_o;
    @(negedge clk);
    csr_access_i  = 1'b0;
    dbg_csr_req_i = 1'b0;
  endtask

  task automatic csr_pipe(input csr_op_e op, input logic [11:0] addr, input logic [31:0] wd,
                          output logic [31:0] rd);
    csr_cycle(1'b1, op, addr, wd, 1'b0, 1'b0, '0, '0, rd);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic store_lanes();
    logic [31:0] addr;
    logic [31:0] wd;
    logic [31:0] exp;
    logic [31:0] rd;
    logic        le;
    logic        se;
    int          start;
    int          t;
    int          off;
    start = errors;
    for (t = 0; t < 3; t++) begin
      for (off = 0; off < 4; off++) begin
        if (is_aligned(data_type_e'(t), off)) begin
          // One word per access size
          addr = MEM_BASE + 32'h10 * t + off;
          wd   = $urandom;
          exp  = merge_store(mem[addr[7:2]], data_type_e'(t), off, wd);
          lsu_access(1'b1, data_type_e'(t), 1'b0, addr, wd, rd, le, se);
          check("stored word", mem[addr[7:2]], exp);
          check("store error flags", {30'b0, le, se}, 32'b0);
        end
      end
    end
    report_test("stores", start);
  endtask

  task automatic load_extension();
    logic [31:0] addr;
    logic [31:0] rd;
    logic        le;
    logic        se;
    int          start;
    int          w;
    int          t;
    int          off;
    int          sx;
    start = errors;
    // Bytes and halves with both sign bit values
    mem[16] = 32'h7F80_01FE;
    for (w = 0; w < 2; w++) begin
      for (t = 0; t < 3; t++) begin
        for (off = 0; off < 4; off++) begin
          for (sx = 0; sx < 2; sx++) begin
            if (is_aligned(data_type_e'(t), off)) begin
              addr = MEM_BASE + 32'h40 + 32'h44 * w + off;
              lsu_access(1'b0, data_type_e'(t), sx[0], addr, '0, rd, le, se);
              check("load data", rd,
                    load_expect(mem[addr[7:2]], data_type_e'(t), off, sx[0]));
              check("load error flags", {30'b0, le, se}, 32'b0);
            end
          end
        end
      end
    end
    report_test("loads", start);
  endtask

  task automatic misaligned_reject();
    logic saw_mis;
    logic saw_req;
    int   start;
    int   t;
    int   off;
    int   n;
    start = errors;
    for (t = 0; t < 2; t++) begin
      for (off = 1; off < 4; off++) begin
        if (!is_aligned(data_type_e'(t), off)) begin
          saw_mis = 1'b0;
          saw_req = 1'b0;
          n       = 0;
          @(negedge clk);
          lsu_req_i  = 1'b1;
          lsu_we_i   = off[0];
          lsu_type_i = data_type_e'(t);
          lsu_addr_i = MEM_BASE + 32'h20 + off;
          @(negedge clk);
          lsu_req_i = 1'b0;
          while (lsu_busy_o && n < TIMEOUT) begin
            saw_mis = saw_mis | misaligned_o;
            saw_req = saw_req | data_req_o;
            @(negedge clk);
            n++;
          end
          if (lsu_busy_o) begin
            errors++;
            $display("Timeout: LSU still busy after a misaligned request");
          end
          check("misaligned_o pulse", {31'b0, saw_mis}, 32'd1);
          check("data_req_o on misaligned", {31'b0, saw_req}, 32'd0);
        end
      end
    end
    report_test("misaligned", start);
  endtask

  task automatic error_response();
    logic [31:0] rd;
    logic        le;
    logic        se;
    int          start;
    start = errors;
    lsu_access(1'b0, WORD, 1'b0, ERR_ADDR, '0, rd, le, se);
    check("load error flags", {30'b0, le, se}, 32'b10);
    lsu_access(1'b1, WORD, 1'b0, ERR_ADDR, 32'hDEAD_BEEF, rd, le, se);
    check("store error flags", {30'b0, le, se}, 32'b01);
    report_test("errors", start);
  endtask

  task automatic counter_readback();
    logic [31:0] rd;
    int          start;
    start = errors;
    csr_pipe(NONE, `CSR_LOAD_CNT, '0, rd);
    check("load counter", rd, exp_loads);
    csr_pipe(NONE, `CSR_STORE_CNT, '0, rd);
    check("store counter", rd, exp_stores);
    csr_pipe(NONE, `CSR_ERR_CNT, '0, rd);
    check("error counter", rd, exp_errs);
    // Scratch register read-modify-write
    csr_pipe(WRITE, `CSR_MSCRATCH, 32'h1234_5678, rd);
    check("scratch before write", rd, 32'h0);
    csr_pipe(SET, `CSR_MSCRATCH, 32'h0F00_00F0, rd);
    check("scratch after WRITE", rd, 32'h1234_5678);
    csr_pipe(CLEAR, `CSR_MSCRATCH, 32'h1030_0070, rd);
    check("scratch after SET", rd, 32'h1234_5678 | 32'h0F00_00F0);
    csr_pipe(NONE, `CSR_MSCRATCH, '0, rd);
    check("scratch after CLEAR", rd, (32'h1234_5678 | 32'h0F00_00F0) & ~32'h1030_0070);
    report_test("counters", start);
  endtask

  task automatic debug_override();
    logic [31:0] rd;
    logic [11:0] cnt_addr;
    int          start;
    int          i;
    start = errors;
    // Debug write against a pipeline SET in the same cycle
    csr_cycle(1'b1, SET, `CSR_MSCRATCH, 32'hFFFF_0000,
              1'b1, 1'b1, `CSR_MSCRATCH, 32'hA5A5_0101, rd);
    // Debug read against a pipeline WRITE
    csr_cycle(1'b1, WRITE, `CSR_MSCRATCH, 32'h0BAD_0BAD,
              1'b1, 1'b0, `CSR_MSCRATCH, '0, rd);
    check("debug read of scratch", rd, 32'hA5A5_0101);
    csr_pipe(NONE, `CSR_MSCRATCH, '0, rd);
    check("scratch after debug read", rd, 32'hA5A5_0101);
    // Debug writes clear the counters
    for (i = 0; i < 3; i++) begin
      cnt_addr = `CSR_LOAD_CNT + `CSR_ADDR_W'(i);
      csr_cycle(1'b0, NONE, '0, '0, 1'b1, 1'b1, cnt_addr, '0, rd);
      csr_cycle(1'b0, NONE, '0, '0, 1'b1, 1'b0, cnt_addr, '0, rd);
      check("counter after clear", rd, 32'h0);
    end
    report_test("debug", start);
  endtask

  initial begin
    int i;
    void'($urandom(SEED));
    checks          = 0;
    errors          = 0;
    exp_loads       = 0;
    exp_stores      = 0;
    exp_errs        = 0;
    rst_ni          = 1'b0;
    lsu_req_i       = 1'b0;
    lsu_we_i        = 1'b0;
    lsu_type_i      = WORD;
    lsu_sign_ext_i  = 1'b0;
    lsu_addr_i      = '0;
    lsu_wdata_i     = '0;
    csr_access_i    = 1'b0;
    csr_op_i        = NONE;
    csr_addr_i      = '0;
    csr_wdata_i     = '0;
    dbg_csr_req_i   = 1'b0;
    dbg_csr_addr_i  = '0;
    dbg_csr_we_i    = 1'b0;
    dbg_csr_wdata_i = '0;
    for (i = 0; i < 64; i++) begin
      mem[i] = fill_word(MEM_BASE + 4 * i);
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_ni = 1'b1;

    store_lanes();
    load_extension();
    misaligned_reject();
    error_response();
    counter_readback();
    debug_override();

    $display("Ran %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
